// File: all.f
+incdir+tb
verilog/mix_params_pkg.sv
verilog/mix_types_pkg.sv
verilog/fir_interp6.sv
verilog/interp4.sv
verilog/gain_stage.sv
verilog/audio_mixer.sv
tb/mixer_tb.sv

// File: tb/mixer_tb_tasks.svh
// testbench helpers: steady stimulus, settling, test bookkeeping,
// the DC reference model and the typed compare task

// holds the inputs and strobes a sample once per sample period
task automatic apply_steady(
	input logic signed [FM_W-1:0] left_val,
	input logic signed [FM_W-1:0] right_val,
	input logic [PSG_W-1:0]       psg_val,
	input logic                   fm_on,
	input logic                   psg_on,
	input vol_level_e             level
);
	@(posedge clk);
	fm_left    <= left_val;
	fm_right   <= right_val;
	psg        <= psg_val;
	enable_fm  <= fm_on;
	enable_psg <= psg_on;
	volume     <= level;
	for (int n = 0; n < STEADY_PERIODS; n++) begin
		@(posedge clk);
		sample <= 1'b1;
		@(posedge clk);
		sample <= 1'b0;
		repeat (SAMPLE_PERIOD - 2) @(posedge clk);
	end
endtask

// waits a number of rising edges, then the falling edge where outputs are stable
task automatic settle(input int cycles);
	repeat (cycles) @(posedge clk);
	@(negedge clk);
endtask

task automatic begin_test(input string name);
	test_name   = name;
	test_errors = 0;
endtask

task automatic end_test();
	if (test_errors == 0) begin
		tests_passed++;
		$display("test %s: passed", test_name);
	end else begin
		tests_failed++;
		$display("test %s: failed with %0d errors", test_name, test_errors);
	end
endtask

task automatic check_sample(
	input string                   what,
	input logic signed [OUT_W-1:0] expected,
	input logic signed [OUT_W-1:0] actual
);
	if (actual !== expected) begin
		$display("MISMATCH %s: expected %0d, actual %0d", what, expected, actual);
		test_errors++;
		error_count++;
	end
endtask

// the PSG enters the mix as its upper 9 bits read as a signed sample
function automatic int psg_level(input logic [PSG_W-1:0] raw, input logic on);
	logic signed [FM_W-1:0] cut;
	cut = raw[PSG_W-1 -: FM_W];
	return on ? int'(cut) : 0;
endfunction

// DC rule: (F + P/4) * 64, then the selected gain, then saturation to 16 bits
function automatic logic signed [OUT_W-1:0] expected_output(
	input int         f,
	input int         p,
	input vol_level_e level
);
	int base;
	int g;
	base = (f + (p >>> 2)) * 64;
	case (level)
		VOL_QUARTER: g = base >>> 2;
		VOL_HALF:    g = base >>> 1;
		VOL_X2:      g = base * 2;
		VOL_X4:      g = base * 4;
		VOL_X8:      g = base * 8;
		VOL_X16:     g = base * 16;
		VOL_X32:     g = base * 32;
		default:     g = base;
	endcase
	if (g > 32767)
		g = 32767;
	else if (g < -32768)
		g = -32768;
	return g[OUT_W-1:0];
endfunction

// File: tb/mixer_tb.sv
// testbench of the output mixer: clock, reset, DUT, watchdog, directed tests
// and the final verdict
`timescale 1ns/1ps

module mixer_tb
	import mix_params_pkg::*, mix_types_pkg::*;
();

	localparam int SAMPLE_PERIOD  = 80;
	localparam int STEADY_PERIODS = 10;
	localparam int NUM_TESTS      = 6;
	localparam int RESET_CYCLES   = 10;
	// 12 sample periods per test at 10 ns per clock, plus the reset
	localparam int WATCHDOG_NS    = NUM_TESTS * 12 * SAMPLE_PERIOD * 10 + RESET_CYCLES * 10;

	logic clk;
	logic arst_n;
	logic sample;
	logic signed [FM_W-1:0] fm_left;
	logic signed [FM_W-1:0] fm_right;
	logic [PSG_W-1:0] psg;
	logic enable_fm;
	logic enable_psg;
	vol_level_e volume;
	logic signed [OUT_W-1:0] left_out;
	logic signed [OUT_W-1:0] right_out;

	int error_count;
	int test_errors;
	int tests_passed;
	int tests_failed;
	string test_name;
	int unsigned seed_value;

	`include "mixer_tb_tasks.svh"

	audio_mixer UUT (
		.clk        (clk),
		.arst_n     (arst_n),
		.sample     (sample),
		.fm_left    (fm_left),
		.fm_right   (fm_right),
		.psg        (psg),
		.enable_fm  (enable_fm),
		.enable_psg (enable_psg),
		.volume     (volume),
		.left_out   (left_out),
		.right_out  (right_out)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display(">>> FAIL");
		$finish;
	end

	// outputs are checked inside reset and one clock after its release
	task automatic reset_outputs();
		begin_test("reset");
		repeat (RESET_CYCLES - 1) @(posedge clk);
		@(negedge clk);
		check_sample("reset left during", 16'sd0, left_out);
		check_sample("reset right during", 16'sd0, right_out);
		@(posedge clk);
		arst_n <= 1'b1;
		settle(1);
		check_sample("reset left after", 16'sd0, left_out);
		check_sample("reset right after", 16'sd0, right_out);
		end_test();
	endtask

	task automatic sources_off();
		logic [PSG_W-1:0] p;
		vol_level_e lvl;
		begin_test("sources_off");
		p   = PSG_W'($urandom);
		lvl = vol_level_e'($urandom_range(7, 0));
		apply_steady(FM_W'($urandom), FM_W'($urandom), p, 1'b0, 1'b0, lvl);
		settle(2);
		check_sample("sources_off left", expected_output(0, psg_level(p, 1'b0), lvl), left_out);
		check_sample("sources_off right", expected_output(0, psg_level(p, 1'b0), lvl), right_out);
		end_test();
	endtask

	// different values per channel show that left and right do not mix
	task automatic fm_dc();
		logic signed [FM_W-1:0] f_l;
		logic signed [FM_W-1:0] f_r;
		begin_test("fm_dc");
		f_l = FM_W'($urandom);
		f_r = FM_W'($urandom);
		while (f_r == f_l)
			f_r = FM_W'($urandom);
		apply_steady(f_l, f_r, PSG_W'($urandom), 1'b1, 1'b0, VOL_UNITY);
		settle(2);
		check_sample("fm_dc left", expected_output(f_l, 0, VOL_UNITY), left_out);
		check_sample("fm_dc right", expected_output(f_r, 0, VOL_UNITY), right_out);
		end_test();
	endtask

	// both channels are held to the same expected value, so they must match each other
	task automatic psg_dc();
		logic [PSG_W-1:0] p;
		begin_test("psg_dc");
		p = PSG_W'($urandom);
		apply_steady(FM_W'($urandom), FM_W'($urandom), p, 1'b0, 1'b1, VOL_UNITY);
		settle(2);
		check_sample("psg_dc left", expected_output(0, psg_level(p, 1'b1), VOL_UNITY), left_out);
		check_sample("psg_dc right", expected_output(0, psg_level(p, 1'b1), VOL_UNITY), right_out);
		end_test();
	endtask

	// one steady mix, then volume alone walks through every level
	task automatic gain_sweep();
		logic signed [FM_W-1:0] f_l;
		logic signed [FM_W-1:0] f_r;
		logic [PSG_W-1:0] p;
		vol_level_e lvl;
		begin_test("all_gains");
		f_l = 9'sd37;
		f_r = -9'sd53;
		p   = 12'h2C8;
		apply_steady(f_l, f_r, p, 1'b1, 1'b1, VOL_QUARTER);
		for (int i = 0; i < 8; i++) begin
			lvl = vol_level_e'(i);
			@(posedge clk);
			volume <= lvl;
			settle(2);
			check_sample($sformatf("all_gains %s left", lvl.name()),
				expected_output(f_l, psg_level(p, 1'b1), lvl), left_out);
			check_sample($sformatf("all_gains %s right", lvl.name()),
				expected_output(f_r, psg_level(p, 1'b1), lvl), right_out);
		end
		end_test();
	endtask

	task automatic saturation();
		begin_test("saturation");
		apply_steady(9'sd250, -9'sd250, 12'h0, 1'b1, 1'b0, VOL_X32);
		settle(2);
		check_sample("saturation left", expected_output(250, 0, VOL_X32), left_out);
		check_sample("saturation right", expected_output(-250, 0, VOL_X32), right_out);
		end_test();
	endtask

	initial begin
		seed_value   = $urandom(83);
		error_count  = 0;
		test_errors  = 0;
		tests_passed = 0;
		tests_failed = 0;
		arst_n       = 1'b0;
		sample       = 1'b0;
		fm_left      = '0;
		fm_right     = '0;
		psg          = '0;
		enable_fm    = 1'b0;
		enable_psg   = 1'b0;
		volume       = VOL_UNITY;

		reset_outputs();
		sources_off();
		fm_dc();
		psg_dc();
		gain_sweep();
		saturation();

		$display("tests passed: %0d, tests failed: %0d, errors: %0d",
			tests_passed, tests_failed, error_count);
		if (error_count == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: verilog/audio_mixer.sv
// mixer top: source gating, interpolation by 6 and by 4, PSG mix-in and
// the output gain
`timescale 1ns/1ps

module audio_mixer import mix_params_pkg::*, mix_types_pkg::*; (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    sample,
	input  logic signed [FM_W-1:0]  fm_left,
	input  logic signed [FM_W-1:0]  fm_right,
	input  logic [PSG_W-1:0]        psg,
	input  logic                    enable_fm,
	input  logic                    enable_psg,
	input  vol_level_e              volume,
	output logic signed [OUT_W-1:0] left_out,
	output logic signed [OUT_W-1:0] right_out
);

	// PSG path before the FIR
	logic [PSG_W-1:0] psg_gated;
	logic signed [FM_W-1:0] psg_cut;

	// results of the two interpolate-by-6 instances
	logic signed [ACC_W-1:0] fir6_left;
	logic signed [ACC_W-1:0] fir6_right;
	logic fir6_strobe;
	logic signed [ACC_W-1:0] psg_fir6;

	// inputs of the interpolate-by-4 stage
	logic signed [FM_W-1:0] fm_gated_left;
	logic signed [FM_W-1:0] fm_gated_right;
	logic signed [ACC_W-1:0] psg_att;
	logic signed [FM_W-1:0] psg_side;

	// interpolate-by-4 results
	logic signed [ACC_W-1:0] fir4_left;
	logic signed [ACC_W-1:0] fir4_right;

	// the PSG is treated as a signed 9-bit sample made from its upper bits
	assign psg_gated = enable_psg ? psg : '0;
	assign psg_cut   = psg_gated[PSG_W-1 -: FM_W];

	fir_interp6 u_fir6_fm (
		.clk        (clk),
		.arst_n     (arst_n),
		.sample     (sample),
		.left_in    (fm_left),
		.right_in   (fm_right),
		.left_out   (fir6_left),
		.right_out  (fir6_right),
		.out_strobe (fir6_strobe)
	);

	// mono source, the right channel is tied off and its output ignored
	// this instance runs in lock step with the FM one, so its strobe is left open
	fir_interp6 u_fir6_psg (
		.clk        (clk),
		.arst_n     (arst_n),
		.sample     (sample),
		.left_in    (psg_cut),
		.right_in   ('0),
		.left_out   (psg_fir6),
		.right_out  (),
		.out_strobe ()
	);

	// the FIR carries a DC gain of 2^11, the upper bits bring FM back to sample scale
	assign fm_gated_left  = enable_fm ? fir6_left[ACC_W-1 -: FM_W] : '0;
	assign fm_gated_right = enable_fm ? fir6_right[ACC_W-1 -: FM_W] : '0;

	// PSG at a quarter of its level, so it sits at a level comparable to the FM
	assign psg_att  = psg_fir6 >>> 2;
	assign psg_side = psg_att[ACC_W-1 -: FM_W];

	// the gain stage registers every clock, so the 4x rate strobe is not needed further on
	interp4 u_interp4 (
		.clk         (clk),
		.arst_n      (arst_n),
		.in_strobe   (fir6_strobe),
		.left_in     (fm_gated_left),
		.right_in    (fm_gated_right),
		.left_other  (psg_side),
		.right_other (psg_side),
		.left_out    (fir4_left),
		.right_out   (fir4_right),
		.out_strobe  ()
	);

	gain_stage u_gain (
		.clk       (clk),
		.arst_n    (arst_n),
		.left_in   (fir4_left[ACC_W-1 -: OUT_W]),
		.right_in  (fir4_right[ACC_W-1 -: OUT_W]),
		.volume    (volume),
		.left_out  (left_out),
		.right_out (right_out)
	);

endmodule

// File: verilog/fir_interp6.sv
// stereo polyphase FIR, interpolation by 6 on a single multiply-accumulate
`timescale 1ns/1ps

module fir_interp6 import mix_params_pkg::*, mix_types_pkg::*; (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    sample,
	input  logic signed [FM_W-1:0]  left_in,
	input  logic signed [FM_W-1:0]  right_in,
	output logic signed [ACC_W-1:0] left_out,
	output logic signed [ACC_W-1:0] right_out,
	output logic                    out_strobe
);

	// the accumulator has two guard bits, negative taps can overshoot
	function automatic logic signed [ACC_W-1:0] clip(input logic signed [ACC_W+1:0] v);
		logic [2:0] top;
		logic signed [ACC_W-1:0] res;
		top = v[ACC_W+1:ACC_W-1];
		if (top == 3'b000 || top == 3'b111)
			res = v[ACC_W-1:0];
		else if (v[ACC_W+1])
			res = {1'b1, {(ACC_W-1){1'b0}}};
		else
			res = {1'b0, {(ACC_W-1){1'b1}}};
		return res;
	endfunction

	fir_state_e state;
	logic [2:0] phase;
	logic [1:0] tap;
	logic [3:0] slot;
	logic [$clog2(MIN_SAMPLE_GAP+1)-1:0] gap_cnt;
	logic accept;

	// four newest samples per channel, index 0 is the latest
	logic signed [FM_W-1:0] hist_l [4];
	logic signed [FM_W-1:0] hist_r [4];

	logic signed [11:0] mac_coef;
	logic signed [FM_W-1:0] mac_data;
	logic signed [ACC_W+1:0] product;
	logic signed [ACC_W+1:0] acc_l;
	logic signed [ACC_W+1:0] acc_r;

	// a strobe only counts once the previous sample had time for all six phases
	assign accept = sample && (gap_cnt == MIN_SAMPLE_GAP);

	// one multiplier serves both channels, the state picks the history
	assign mac_coef = FIR6_COEF[{phase, tap}];
	assign mac_data = (state == FIR_MAC_R) ? hist_r[tap] : hist_l[tap];
	assign product  = mac_coef * mac_data;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= FIR_IDLE;
			phase      <= '0;
			tap        <= '0;
			slot       <= '0;
			gap_cnt    <= ($clog2(MIN_SAMPLE_GAP+1))'(MIN_SAMPLE_GAP);
			acc_l      <= '0;
			acc_r      <= '0;
			left_out   <= '0;
			right_out  <= '0;
			out_strobe <= 1'b0;
			for (int i = 0; i < 4; i++) begin
				hist_l[i] <= '0;
				hist_r[i] <= '0;
			end
		end else begin
			out_strobe <= 1'b0;
			slot       <= slot + 1'b1;
			if (gap_cnt != MIN_SAMPLE_GAP)
				gap_cnt <= gap_cnt + 1'b1;

			case (state)
				FIR_MAC_L: begin
					acc_l <= acc_l + product;
					tap   <= tap + 1'b1;
					if (tap == 2'd3)
						state <= FIR_MAC_R;
				end
				FIR_MAC_R: begin
					acc_r <= acc_r + product;
					tap   <= tap + 1'b1;
					if (tap == 2'd3)
						state <= FIR_WAIT;
				end
				FIR_WAIT: begin
					// the phase slot is over, publish the pair and clear for the next one
					if (slot == PHASE6_SPACING - 1) begin
						left_out   <= clip(acc_l);
						right_out  <= clip(acc_r);
						out_strobe <= 1'b1;
						acc_l      <= '0;
						acc_r      <= '0;
						slot       <= '0;
						if (phase == FIR6_TAPS / 4 - 1) begin
							state <= FIR_IDLE;
						end else begin
							phase <= phase + 1'b1;
							state <= FIR_MAC_L;
						end
					end
				end
				default: slot <= '0;
			endcase

			// a new sample restarts at phase 0 and wins over the transitions above
			if (accept) begin
				hist_l[0] <= left_in;
				hist_r[0] <= right_in;
				for (int i = 3; i > 0; i--) begin
					hist_l[i] <= hist_l[i-1];
					hist_r[i] <= hist_r[i-1];
				end
				state   <= FIR_MAC_L;
				phase   <= '0;
				tap     <= '0;
				slot    <= '0;
				acc_l   <= '0;
				acc_r   <= '0;
				gap_cnt <= 1;
			end
		end
	end

endmodule

// File: verilog/gain_stage.sv
// eight-step output gain with saturation and a registered stereo result
`timescale 1ns/1ps

module gain_stage import mix_params_pkg::*, mix_types_pkg::*; (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic signed [OUT_W-1:0] left_in,
	input  logic signed [OUT_W-1:0] right_in,
	input  vol_level_e              volume,
	output logic signed [OUT_W-1:0] left_out,
	output logic signed [OUT_W-1:0] right_out
);

	// applies one gain level, five guard bits cover the x32 shift
	function automatic logic signed [OUT_W-1:0] scale(
		input logic signed [OUT_W-1:0] x,
		input vol_level_e level
	);
		logic signed [OUT_W+5:0] wide;
		logic [6:0] top;
		logic signed [OUT_W-1:0] res;
		case (level)
			VOL_QUARTER: wide = (OUT_W+6)'(x >>> 2);
			VOL_HALF:    wide = (OUT_W+6)'(x >>> 1);
			VOL_X2:      wide = (OUT_W+6)'(x) <<< 1;
			VOL_X4:      wide = (OUT_W+6)'(x) <<< 2;
			VOL_X8:      wide = (OUT_W+6)'(x) <<< 3;
			VOL_X16:     wide = (OUT_W+6)'(x) <<< 4;
			VOL_X32:     wide = (OUT_W+6)'(x) <<< 5;
			default:     wide = (OUT_W+6)'(x);
		endcase
		// the value fits when every bit above the output sign matches it
		top = wide[OUT_W+5:OUT_W-1];
		if (top == '0 || top == '1)
			res = wide[OUT_W-1:0];
		else if (wide[OUT_W+5])
			res = {1'b1, {(OUT_W-1){1'b0}}};
		else
			res = {1'b0, {(OUT_W-1){1'b1}}};
		return res;
	endfunction

	// every gain level is computed in parallel, volume only picks one
	logic signed [OUT_W-1:0] gain_l [8];
	logic signed [OUT_W-1:0] gain_r [8];

	for (genvar i = 0; i < 8; i++) begin : g_level
		assign gain_l[i] = scale(left_in, vol_level_e'(i));
		assign gain_r[i] = scale(right_in, vol_level_e'(i));
	end

	// volume may change at any time, the register keeps the output glitch free
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			left_out  <= '0;
			right_out <= '0;
		end else begin
			left_out  <= gain_l[volume];
			right_out <= gain_r[volume];
		end
	end

endmodule

// File: verilog/interp4.sv
// linear interpolator by 4 with a side input summed into each channel
`timescale 1ns/1ps

module interp4 import mix_params_pkg::*, mix_types_pkg::*; (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    in_strobe,
	input  logic signed [FM_W-1:0]  left_in,
	input  logic signed [FM_W-1:0]  right_in,
	input  logic signed [FM_W-1:0]  left_other,
	input  logic signed [FM_W-1:0]  right_other,
	output logic signed [ACC_W-1:0] left_out,
	output logic signed [ACC_W-1:0] right_out,
	output logic                    out_strobe
);

	fir_state_e state;
	logic [1:0] phase;
	logic [1:0] slot;

	// main plus side input, one bit wider so the sum cannot wrap
	logic signed [FM_W:0] sum_l;
	logic signed [FM_W:0] sum_r;
	logic signed [FM_W:0] prev_l;
	logic signed [FM_W:0] prev_r;
	logic signed [FM_W:0] cur_l;
	logic signed [FM_W:0] cur_r;

	logic signed [FM_W:0] mac_prev;
	logic signed [FM_W:0] mac_cur;
	logic signed [FM_W+1:0] mac_diff;
	logic signed [11:0] weight;
	logic signed [ACC_W+2:0] blend;
	logic signed [ACC_W-1:0] acc_l;
	logic signed [ACC_W-1:0] acc_r;

	assign sum_l = (FM_W+1)'(left_in) + (FM_W+1)'(left_other);
	assign sum_r = (FM_W+1)'(right_in) + (FM_W+1)'(right_other);

	// weight of the current sum grows by one step per phase and reaches 1024 at phase 3
	assign weight = 12'(INTERP4_STEP * (int'(phase) + 1));

	// prev*1024 + (cur-prev)*w equals prev*(1024-w) + cur*w with a single variable product
	assign mac_prev = (state == FIR_MAC_R) ? prev_r : prev_l;
	assign mac_cur  = (state == FIR_MAC_R) ? cur_r : cur_l;
	assign mac_diff = (FM_W+2)'(mac_cur) - (FM_W+2)'(mac_prev);
	assign blend    = mac_prev * (ACC_W+3)'(4 * INTERP4_STEP) + mac_diff * weight;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= FIR_IDLE;
			phase      <= '0;
			slot       <= '0;
			prev_l     <= '0;
			prev_r     <= '0;
			cur_l      <= '0;
			cur_r      <= '0;
			acc_l      <= '0;
			acc_r      <= '0;
			left_out   <= '0;
			right_out  <= '0;
			out_strobe <= 1'b0;
		end else begin
			out_strobe <= 1'b0;
			slot       <= slot + 1'b1;

			case (state)
				FIR_MAC_L: begin
					acc_l <= blend[ACC_W-1:0];
					state <= FIR_MAC_R;
				end
				FIR_MAC_R: begin
					acc_r <= blend[ACC_W-1:0];
					state <= FIR_WAIT;
				end
				FIR_WAIT: begin
					if (slot == PHASE4_SPACING - 1) begin
						left_out   <= acc_l;
						right_out  <= acc_r;
						out_strobe <= 1'b1;
						slot       <= '0;
						if (phase == 2'd3) begin
							state <= FIR_IDLE;
						end else begin
							phase <= phase + 1'b1;
							state <= FIR_MAC_L;
						end
					end
				end
				default: slot <= '0;
			endcase

			// the next input lands on the same edge as the last strobe, so it takes priority
			if (in_strobe) begin
				prev_l <= cur_l;
				prev_r <= cur_r;
				cur_l  <= sum_l;
				cur_r  <= sum_r;
				phase  <= '0;
				slot   <= '0;
				state  <= FIR_MAC_L;
			end
		end
	end

endmodule

// File: verilog/mix_params_pkg.sv
// numeric constants of the output mixer: sample widths, FIR coefficients,
// interpolation weights and the spacing of the rate stages
package mix_params_pkg;

	// signed FM sample, also the PSG value once cut down to its upper bits
	localparam int FM_W = 9;

	// raw PSG level as it leaves the tone generator, unsigned
	localparam int PSG_W = 12;

	// signed results of the FIR and of the linear interpolator
	localparam int ACC_W = 20;

	// signed stereo output
	localparam int OUT_W = 16;

	// polyphase prototype, 6 phases of 4 taps
	// the index is phase*4 + tap and tap 0 multiplies the newest sample
	// every phase sums to exactly 2048 so DC passes with a gain of 2^11
	localparam int FIR6_TAPS = 24;
	localparam logic signed [11:0] FIR6_COEF [FIR6_TAPS] = '{
		-12'sd48,  12'sd768,  12'sd1448, -12'sd120,
		-12'sd88,  12'sd888,  12'sd1344, -12'sd96,
		-12'sd112, 12'sd1008, 12'sd1216, -12'sd64,
		-12'sd64,  12'sd1216, 12'sd1008, -12'sd112,
		-12'sd96,  12'sd1344, 12'sd888,  -12'sd88,
		-12'sd120, 12'sd1448, 12'sd768,  -12'sd48
	};

	// clocks between two result pairs of the interpolate-by-6 FIR
	localparam int PHASE6_SPACING = 12;

	// weight step of the interpolate-by-4 stage, four steps make 1024
	localparam int INTERP4_STEP = 256;

	// clocks between two result pairs of the interpolate-by-4 stage
	localparam int PHASE4_SPACING = 3;

	// input strobes closer than this are dropped, six FIR phases must fit
	localparam int MIN_SAMPLE_GAP = 6 * PHASE6_SPACING;

endpackage

// File: verilog/mix_types_pkg.sv
// enums of the mixer: gain settings and rate stage sequencer states
package mix_types_pkg;

	// output gain, the encoding matches the 3-bit volume register
	typedef enum logic [2:0] {
		VOL_QUARTER = 3'd0,
		VOL_HALF    = 3'd1,
		VOL_UNITY   = 3'd2,
		VOL_X2      = 3'd3,
		VOL_X4      = 3'd4,
		VOL_X8      = 3'd5,
		VOL_X16     = 3'd6,
		VOL_X32     = 3'd7
	} vol_level_e;

	// sequencer of the time-shared multiplier in both rate stages
	// left channel work, then right channel work, then idle slots
	// until the next result is due
	typedef enum logic [1:0] {
		FIR_IDLE  = 2'd0,
		FIR_MAC_L = 2'd1,
		FIR_MAC_R = 2'd2,
		FIR_WAIT  = 2'd3
	} fir_state_e;

endpackage
